/* project.f */
+incdir+verilog
+incdir+tb
verilog/router_pkg.sv
verilog/bus_addr_decode.sv
verilog/target_arbiter.sv
verilog/read_return.sv
verilog/mem_router.sv
tb/mem_router_sva.sv
tb/mem_router_tb.sv

/* tb/mem_router_sva.sv */
`timescale 1ns/1ps

module mem_router_sva (
    input logic              clk,
    input logic              reset,
    input router_pkg::mode_e mode,
    input logic              loader_ready,
    input logic              imem_ready,
    input logic              dmem_ready,
    input logic [2:0]        loader_grant,
    input logic [2:0]        imem_grant,
    input logic [2:0]        dmem_grant
);

    int fail_count = 0;

    core_idle_in_boot: assert property (@(posedge clk) disable iff (reset)
        mode == router_pkg::MODE_BOOT |-> !imem_ready && !dmem_ready)
    else begin
        fail_count++;
        $error("core port ready in boot mode");
    end

    loader_idle_in_run: assert property (@(posedge clk) disable iff (reset)
        mode == router_pkg::MODE_RUN |-> !loader_ready)
    else begin
        fail_count++;
        $error("loader ready in run mode");
    end

    // At most one grant per target
    single_grant: assert property (@(posedge clk) disable iff (reset)
        ((loader_grant & imem_grant) | (loader_grant & dmem_grant)
         | (imem_grant & dmem_grant)) == 3'b000)
    else begin
        fail_count++;
        $error("target granted to two requesters");
    end

endmodule

bind target_arbiter mem_router_sva arbiter_sva (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .loader_ready (loader_ready),
    .imem_ready   (imem_ready),
    .dmem_ready   (dmem_ready),
    .loader_grant (loader_grant),
    .imem_grant   (imem_grant),
    .dmem_grant   (dmem_grant)
);

/* tb/router_tests.svh */
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

////////////////////////////////////////////////////////////
// Compare helpers
////////////////////////////////////////////////////////////

task automatic flag_failure(string name, string what);
    error_count++;
    $display("** Error: %s: %s", name, what);
endtask

task automatic check_cmd(string name, router_pkg::tgt_cmd_t exp, router_pkg::tgt_cmd_t act);
    if (act !== exp) begin
        error_count++;
        $display("** Error: %s: expected cmd %h/%h/%b/%b, actual %h/%h/%b/%b", name,
                 exp.word_addr, exp.wdata, exp.write, exp.wben,
                 act.word_addr, act.wdata, act.write, act.wben);
    end
endtask

task automatic check_word(string name, router_pkg::word_t exp, router_pkg::word_t act);
    if (act !== exp) begin
        error_count++;
        $display("** Error: %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_src(string name, router_pkg::src_e exp, router_pkg::src_e act);
    if (act !== exp) begin
        error_count++;
        $display("** Error: %s: expected winner %s, actual %s", name, exp.name(), act.name());
    end
endtask

// Address from region bits 15:14 and word index in bits 13:2
function automatic router_pkg::bus_req_t make_req(router_pkg::target_e tgt, int idx,
                                                  logic write, router_pkg::word_t wdata);
    router_pkg::bus_req_t r;
    r.addr  = {tgt == router_pkg::TGT_REG, tgt == router_pkg::TGT_DATA,
               idx[`WORD_ADDR_W-1:0], 2'b00};
    r.wdata = wdata;
    r.write = write;
    r.size  = router_pkg::SIZE_WORD;
    return r;
endfunction

// One loader write, then the command check in the following cycle
task automatic loader_write(string name, router_pkg::bus_req_t r,
                            router_pkg::target_e tgt, router_pkg::tgt_cmd_t exp);
    int waited;
    waited = 0;
    @(posedge clk);
    loader_valid <= 1'b1;
    loader_req   <= r;
    do begin
        @(negedge clk);
        waited++;
        if (imem_ready || dmem_ready) begin
            flag_failure(name, "core port ready in boot mode");
        end
    end while (!loader_ready && waited < 10);
    if (!loader_ready) begin
        flag_failure(name, "loader write never accepted");
    end
    @(posedge clk);
    loader_valid <= 1'b0;
    @(negedge clk);
    if (!cmd_valid[tgt]) begin
        flag_failure(name, "no command at the target");
    end
    check_cmd(name, exp, cmd[tgt]);
endtask

task automatic finish_boot();
    @(posedge clk);
    imem_valid <= 1'b0;
    dmem_valid <= 1'b0;
    boot_done  <= 1'b1;
    @(posedge clk);
    boot_done  <= 1'b0;
endtask

// Read on imem alone, response two cycles after acceptance
task automatic imem_read(string name, router_pkg::target_e tgt, int idx,
                         router_pkg::word_t exp);
    @(posedge clk);
    imem_valid <= 1'b1;
    imem_req   <= make_req(tgt, idx, 1'b0, '0);
    @(negedge clk);
    if (!imem_ready) begin
        flag_failure(name, "imem not ready in run mode");
    end
    @(posedge clk);
    imem_valid <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    if (!imem_rsp_valid) begin
        flag_failure(name, "imem read got no response");
    end
    check_word(name, exp, imem_rsp_rdata);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic boot_load_test();
    router_pkg::tgt_cmd_t exp;
    // Core ports keep asking, boot mode must hold them off
    imem_valid <= 1'b1;
    imem_req   <= make_req(router_pkg::TGT_INST, 0, 1'b0, '0);
    dmem_valid <= 1'b1;
    dmem_req   <= make_req(router_pkg::TGT_DATA, 0, 1'b0, '0);
    for (int t = 0; t < 3; t++) begin
        for (int i = 0; i < 4; i++) begin
            boot_data[t][i] = $urandom;
            exp = '{i[`WORD_ADDR_W-1:0], boot_data[t][i], 1'b1, 4'b1111};
            loader_write("boot_load",
                         make_req(router_pkg::target_e'(t), i, 1'b1, boot_data[t][i]),
                         router_pkg::target_e'(t), exp);
        end
    end
endtask

task automatic byte_enable_test();
    router_pkg::bus_req_t r;
    router_pkg::tgt_cmd_t exp;
    int idx;
    for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off++) begin
            idx          = 8 + 4 * s + off;
            r            = make_req(router_pkg::TGT_DATA, idx, 1'b1, $urandom);
            r.size       = router_pkg::size_e'(s);
            r.addr[1:0]  = off[1:0];
            exp          = '{idx[`WORD_ADDR_W-1:0], r.wdata, 1'b1, 4'b0000};
            case (r.size)
                router_pkg::SIZE_BYTE: exp.wben = 4'b0001 << off;
                router_pkg::SIZE_HALF: exp.wben = (off >= 2) ? 4'b1100 : 4'b0011;
                default:               exp.wben = 4'b1111;
            endcase
            loader_write("byte_enable", r, router_pkg::TGT_DATA, exp);
        end
    end
endtask

task automatic parallel_read_test();
    router_pkg::target_e i_tgt, d_tgt;
    for (int k = 0; k < 3; k++) begin
        i_tgt = router_pkg::target_e'(k);
        d_tgt = router_pkg::target_e'((k + 1) % 3);
        @(posedge clk);
        imem_valid <= 1'b1;
        imem_req   <= make_req(i_tgt, k, 1'b0, '0);
        dmem_valid <= 1'b1;
        dmem_req   <= make_req(d_tgt, k, 1'b0, '0);
        @(negedge clk);
        if (!imem_ready || !dmem_ready) begin
            flag_failure("parallel_read", "core ports not both ready on different targets");
        end
        @(posedge clk);
        imem_valid <= 1'b0;
        dmem_valid <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        if (!imem_rsp_valid || !dmem_rsp_valid) begin
            flag_failure("parallel_read", "missing read response");
        end
        check_word("parallel_read imem", boot_data[i_tgt][k], imem_rsp_rdata);
        check_word("parallel_read dmem", boot_data[d_tgt][k], dmem_rsp_rdata);
    end
endtask

task automatic round_robin_test(router_pkg::target_e tgt, logic imem_first);
    router_pkg::word_t imem_exp [$];
    router_pkg::word_t dmem_exp [$];
    string             name;
    logic              favor_imem, imem_acc, dmem_acc;
    int                imem_next, dmem_next, cycles;
    name       = {"round_robin ", tgt.name()};
    favor_imem = imem_first;
    imem_next  = 0;
    dmem_next  = 0;
    cycles     = 0;
    @(posedge clk);
    imem_valid <= 1'b1;
    imem_req   <= make_req(tgt, 0, 1'b0, '0);
    dmem_valid <= 1'b1;
    dmem_req   <= make_req(tgt, 3, 1'b0, '0);
    while ((imem_next < 4 || dmem_next < 4 || imem_exp.size() > 0 || dmem_exp.size() > 0)
           && cycles < 50) begin
        @(negedge clk);
        cycles++;
        if (imem_rsp_valid) begin
            if (imem_exp.size() == 0) begin
                flag_failure(name, "imem response without a request");
            end else begin
                check_word(name, imem_exp.pop_front(), imem_rsp_rdata);
            end
        end
        if (dmem_rsp_valid) begin
            if (dmem_exp.size() == 0) begin
                flag_failure(name, "dmem response without a request");
            end else begin
                check_word(name, dmem_exp.pop_front(), dmem_rsp_rdata);
            end
        end
        imem_acc = imem_valid && imem_ready;
        dmem_acc = dmem_valid && dmem_ready;
        if (imem_valid && dmem_valid) begin
            if (imem_acc == dmem_acc) begin
                flag_failure(name, "conflict not granted to exactly one port");
            end else begin
                check_src(name, favor_imem ? router_pkg::SRC_IMEM : router_pkg::SRC_DMEM,
                          imem_acc ? router_pkg::SRC_IMEM : router_pkg::SRC_DMEM);
            end
            favor_imem = !favor_imem;
        end else if ((imem_valid && !imem_ready) || (dmem_valid && !dmem_ready)) begin
            flag_failure(name, "lone core request refused");
        end
        @(posedge clk);
        if (imem_acc) begin
            imem_exp.push_back(boot_data[tgt][imem_next]);
            imem_next++;
            if (imem_next < 4) begin
                imem_req <= make_req(tgt, imem_next, 1'b0, '0);
            end else begin
                imem_valid <= 1'b0;
            end
        end
        if (dmem_acc) begin
            dmem_exp.push_back(boot_data[tgt][3 - dmem_next]);
            dmem_next++;
            if (dmem_next < 4) begin
                dmem_req <= make_req(tgt, 3 - dmem_next, 1'b0, '0);
            end else begin
                dmem_valid <= 1'b0;
            end
        end
    end
    if (imem_next < 4 || dmem_next < 4 || imem_exp.size() > 0 || dmem_exp.size() > 0) begin
        flag_failure(name, "requests or responses lost");
    end
endtask

task automatic reset_test();
    router_pkg::word_t    value;
    router_pkg::tgt_cmd_t exp;
    value = $urandom;
    @(posedge clk);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset      <= 1'b0;
    imem_valid <= 1'b1;
    imem_req   <= make_req(router_pkg::TGT_INST, 5, 1'b0, '0);
    dmem_valid <= 1'b1;
    dmem_req   <= make_req(router_pkg::TGT_DATA, 5, 1'b0, '0);
    repeat (4) begin
        @(negedge clk);
        if (imem_ready || dmem_ready) begin
            flag_failure("reset", "core port ready before boot_done");
        end
    end
    exp = '{12'd5, value, 1'b1, 4'b1111};
    loader_write("reset", make_req(router_pkg::TGT_INST, 5, 1'b1, value),
                 router_pkg::TGT_INST, exp);
    finish_boot();
    imem_read("reset", router_pkg::TGT_INST, 5, value);
endtask

`endif

/* tb/mem_router_tb.sv */
`timescale 1ns/1ps
`include "router_defs.svh"

module mem_router_tb;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 200;

    logic                 clk;
    logic                 reset;
    logic                 boot_done;
    logic                 loader_valid, imem_valid, dmem_valid;
    logic                 loader_ready, imem_ready, dmem_ready;
    router_pkg::bus_req_t loader_req, imem_req, dmem_req;
    logic                 imem_rsp_valid, dmem_rsp_valid;
    router_pkg::word_t    imem_rsp_rdata, dmem_rsp_rdata;
    // Indexed by target_e
    logic [2:0]           cmd_valid;
    router_pkg::tgt_cmd_t cmd [3];
    router_pkg::word_t    rdata [3];

    router_pkg::word_t    mem [3][1 << `WORD_ADDR_W];
    router_pkg::word_t    boot_data [3][4];
    int                   error_count;
    int                   assert_fails;

    mem_router dut (
        .clk            (clk),
        .reset          (reset),
        .boot_done      (boot_done),
        .loader_valid   (loader_valid),   .loader_req     (loader_req),
        .loader_ready   (loader_ready),
        .imem_valid     (imem_valid),     .imem_req       (imem_req),
        .imem_ready     (imem_ready),     .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_rdata (imem_rsp_rdata),
        .dmem_valid     (dmem_valid),     .dmem_req       (dmem_req),
        .dmem_ready     (dmem_ready),     .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_rdata (dmem_rsp_rdata),
        .inst_cmd_valid (cmd_valid[0]),   .inst_cmd       (cmd[0]),
        .inst_rdata     (rdata[0]),
        .data_cmd_valid (cmd_valid[1]),   .data_cmd       (cmd[1]),
        .data_rdata     (rdata[1]),
        .reg_cmd_valid  (cmd_valid[2]),   .reg_cmd        (cmd[2]),
        .reg_rdata      (rdata[2])
    );

    // Target models, read data one cycle after the command
    always @(posedge clk) begin
        for (int t = 0; t < 3; t++) begin
            if (cmd_valid[t]) begin
                rdata[t] <= mem[t][cmd[t].word_addr];
                for (int b = 0; b < `WBEN_W; b++) begin
                    if (cmd[t].write && cmd[t].wben[b]) begin
                        mem[t][cmd[t].word_addr][8*b +: 8] <= cmd[t].wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    `include "router_tests.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("** Error: watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h259a_8896));
        error_count  = 0;
        reset        = 1'b1;
        boot_done    = 1'b0;
        loader_valid = 1'b0;
        imem_valid   = 1'b0;
        dmem_valid   = 1'b0;
        loader_req   = '0;
        imem_req     = '0;
        dmem_req     = '0;
        rdata        = '{default: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        boot_load_test();
        byte_enable_test();
        finish_boot();
        parallel_read_test();
        round_robin_test(router_pkg::TGT_INST, 1'b1);
        round_robin_test(router_pkg::TGT_DATA, 1'b0);
        round_robin_test(router_pkg::TGT_REG, 1'b0);
        reset_test();

        assert_fails = dut.arbiter.arbiter_sva.fail_count;
        $display("Check errors: %0d, assertion failures: %0d", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/bus_addr_decode.sv */
`timescale 1ns/1ps
`include "router_defs.svh"

module bus_addr_decode (
    input  router_pkg::bus_req_t req,
    output router_pkg::dec_req_t dec
);

    // Region select bits at the top of the address
    localparam int REG_BIT  = `ADDR_W - 1;
    localparam int DATA_BIT = `ADDR_W - 2;

    localparam logic [`WBEN_W-1:0] LANE0     = {{(`WBEN_W-1){1'b0}}, 1'b1};
    localparam logic [`WBEN_W-1:0] HALF_LOW  = 4'b0011;
    localparam logic [`WBEN_W-1:0] HALF_HIGH = 4'b1100;

    always_comb begin
        dec.wdata = req.wdata;
        dec.write = req.write;

        if (req.addr[REG_BIT]) begin
            dec.target = router_pkg::TGT_REG;
            // Register block only sees a few word slots
            dec.word_addr = {{(`WORD_ADDR_W-`REG_IDX_W){1'b0}},
                             req.addr[`REG_IDX_W+1:2]};
        end else begin
            if (req.addr[DATA_BIT]) begin
                dec.target = router_pkg::TGT_DATA;
            end else begin
                dec.target = router_pkg::TGT_INST;
            end
            dec.word_addr = req.addr[`WORD_ADDR_W+1:2];
        end

        // Byte lanes from size and low address bits
        case (req.size)
            router_pkg::SIZE_BYTE: begin
                dec.wben = LANE0 << req.addr[1:0];
            end
            router_pkg::SIZE_HALF: begin
                dec.wben = req.addr[1] ? HALF_HIGH : HALF_LOW;
            end
            default: begin
                dec.wben = {`WBEN_W{1'b1}};
            end
        endcase
    end

endmodule

/* verilog/mem_router.sv */
`timescale 1ns/1ps

module mem_router (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 boot_done,
    // Boot loader
    input  logic                 loader_valid,
    input  router_pkg::bus_req_t loader_req,
    output logic                 loader_ready,
    // Core instruction port
    input  logic                 imem_valid,
    input  router_pkg::bus_req_t imem_req,
    output logic                 imem_ready,
    output logic                 imem_rsp_valid,
    output router_pkg::word_t    imem_rsp_rdata,
    // Core data port
    input  logic                 dmem_valid,
    input  router_pkg::bus_req_t dmem_req,
    output logic                 dmem_ready,
    output logic                 dmem_rsp_valid,
    output router_pkg::word_t    dmem_rsp_rdata,
    // Targets
    output logic                 inst_cmd_valid,
    output router_pkg::tgt_cmd_t inst_cmd,
    input  router_pkg::word_t    inst_rdata,
    output logic                 data_cmd_valid,
    output router_pkg::tgt_cmd_t data_cmd,
    input  router_pkg::word_t    data_rdata,
    output logic                 reg_cmd_valid,
    output router_pkg::tgt_cmd_t reg_cmd,
    input  router_pkg::word_t    reg_rdata
);

    router_pkg::dec_req_t loader_dec, imem_dec, dmem_dec;
    router_pkg::ret_tag_t inst_tag, data_tag, reg_tag;

    ////////////////////////////////////////////////////////////
    // Decode, arbitrate, return
    ////////////////////////////////////////////////////////////

    bus_addr_decode loader_decode (.req(loader_req), .dec(loader_dec));
    bus_addr_decode imem_decode   (.req(imem_req),   .dec(imem_dec));
    bus_addr_decode dmem_decode   (.req(dmem_req),   .dec(dmem_dec));

    target_arbiter arbiter (
        .clk            (clk),
        .reset          (reset),
        .boot_done      (boot_done),
        .loader_valid   (loader_valid),
        .loader_dec     (loader_dec),
        .imem_valid     (imem_valid),
        .imem_dec       (imem_dec),
        .dmem_valid     (dmem_valid),
        .dmem_dec       (dmem_dec),
        .loader_ready   (loader_ready),
        .imem_ready     (imem_ready),
        .dmem_ready     (dmem_ready),
        .inst_cmd_valid (inst_cmd_valid),
        .inst_cmd       (inst_cmd),
        .data_cmd_valid (data_cmd_valid),
        .data_cmd       (data_cmd),
        .reg_cmd_valid  (reg_cmd_valid),
        .reg_cmd        (reg_cmd),
        .inst_tag       (inst_tag),
        .data_tag       (data_tag),
        .reg_tag        (reg_tag)
    );

    read_return returns (
        .clk            (clk),
        .reset          (reset),
        .inst_tag       (inst_tag),
        .data_tag       (data_tag),
        .reg_tag        (reg_tag),
        .inst_rdata     (inst_rdata),
        .data_rdata     (data_rdata),
        .reg_rdata      (reg_rdata),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_rdata (imem_rsp_rdata),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_rdata (dmem_rsp_rdata)
    );

endmodule

/* verilog/read_return.sv */
`timescale 1ns/1ps

module read_return (
    input  logic                 clk,
    input  logic                 reset,
    input  router_pkg::ret_tag_t inst_tag,
    input  router_pkg::ret_tag_t data_tag,
    input  router_pkg::ret_tag_t reg_tag,
    input  router_pkg::word_t    inst_rdata,
    input  router_pkg::word_t    data_rdata,
    input  router_pkg::word_t    reg_rdata,
    output logic                 imem_rsp_valid,
    output router_pkg::word_t    imem_rsp_rdata,
    output logic                 dmem_rsp_valid,
    output router_pkg::word_t    dmem_rsp_rdata
);

    localparam int NUM_TGT = 3;

    router_pkg::ret_tag_t tag_q [NUM_TGT];
    router_pkg::word_t    rdata [NUM_TGT];

    assign rdata[router_pkg::TGT_INST] = inst_rdata;
    assign rdata[router_pkg::TGT_DATA] = data_rdata;
    assign rdata[router_pkg::TGT_REG]  = reg_rdata;

    // Tags wait one cycle for the target read data
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_TGT; t++) begin
                tag_q[t] <= '0;
            end
        end else begin
            tag_q[router_pkg::TGT_INST] <= inst_tag;
            tag_q[router_pkg::TGT_DATA] <= data_tag;
            tag_q[router_pkg::TGT_REG]  <= reg_tag;
        end
    end

    // A port has at most one read answered per cycle
    always_comb begin
        imem_rsp_valid = 1'b0;
        imem_rsp_rdata = '0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_rdata = '0;
        for (int t = 0; t < NUM_TGT; t++) begin
            if (tag_q[t].read && tag_q[t].src == router_pkg::SRC_IMEM) begin
                imem_rsp_valid = 1'b1;
                imem_rsp_rdata = rdata[t];
            end
            if (tag_q[t].read && tag_q[t].src == router_pkg::SRC_DMEM) begin
                dmem_rsp_valid = 1'b1;
                dmem_rsp_rdata = rdata[t];
            end
        end
    end

endmodule

/* verilog/router_defs.svh */
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Requester bus address width
`define ADDR_W      16
`define DATA_W      32

// RAM word address and byte lanes
`define WORD_ADDR_W 12
`define WBEN_W      4

// Register block index
`define REG_IDX_W   3

`endif

/* verilog/router_pkg.sv */
`include "router_defs.svh"

package router_pkg;

    // Matches the AHB hsize encoding
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } size_e;

    typedef enum logic [1:0] {
        TGT_INST = 2'd0,
        TGT_DATA = 2'd1,
        TGT_REG  = 2'd2
    } target_e;

    typedef enum logic [1:0] {
        SRC_LOADER = 2'd0,
        SRC_IMEM   = 2'd1,
        SRC_DMEM   = 2'd2
    } src_e;

    typedef enum logic {
        MODE_BOOT = 1'b0,
        MODE_RUN  = 1'b1
    } mode_e;

    typedef logic [`DATA_W-1:0] word_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        word_t              wdata;
        logic               write;
        size_e              size;
    } bus_req_t;

    typedef struct packed {
        target_e                 target;
        logic [`WORD_ADDR_W-1:0] word_addr;
        word_t                   wdata;
        logic                    write;
        logic [`WBEN_W-1:0]      wben;
    } dec_req_t;

    typedef struct packed {
        logic [`WORD_ADDR_W-1:0] word_addr;
        word_t                   wdata;
        logic                    write;
        logic [`WBEN_W-1:0]      wben;
    } tgt_cmd_t;

    // Which port a target's next read data belongs to
    typedef struct packed {
        logic read;
        src_e src;
    } ret_tag_t;

endpackage

/* verilog/target_arbiter.sv */
`timescale 1ns/1ps

module target_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 boot_done,
    input  logic                 loader_valid,
    input  router_pkg::dec_req_t loader_dec,
    input  logic                 imem_valid,
    input  router_pkg::dec_req_t imem_dec,
    input  logic                 dmem_valid,
    input  router_pkg::dec_req_t dmem_dec,
    output logic                 loader_ready,
    output logic                 imem_ready,
    output logic                 dmem_ready,
    output logic                 inst_cmd_valid,
    output router_pkg::tgt_cmd_t inst_cmd,
    output logic                 data_cmd_valid,
    output router_pkg::tgt_cmd_t data_cmd,
    output logic                 reg_cmd_valid,
    output router_pkg::tgt_cmd_t reg_cmd,
    output router_pkg::ret_tag_t inst_tag,
    output router_pkg::ret_tag_t data_tag,
    output router_pkg::ret_tag_t reg_tag
);

    localparam int NUM_TGT = 3;
    // Instruction RAM starts favoring imem, the others dmem
    localparam logic [NUM_TGT-1:0] FAVOR_INIT = 3'b001;

    router_pkg::mode_e mode;
    logic [NUM_TGT-1:0] favor_imem;

    logic [NUM_TGT-1:0] loader_want, imem_want, dmem_want;
    logic [NUM_TGT-1:0] loader_grant, imem_grant, dmem_grant;
    logic [NUM_TGT-1:0] conflict;

    router_pkg::tgt_cmd_t cmd_d [NUM_TGT];
    router_pkg::ret_tag_t tag_d [NUM_TGT];
    router_pkg::tgt_cmd_t cmd_q [NUM_TGT];
    router_pkg::ret_tag_t tag_q [NUM_TGT];
    logic [NUM_TGT-1:0]   cmd_valid_q;

    function automatic router_pkg::tgt_cmd_t to_cmd(input router_pkg::dec_req_t d);
        router_pkg::tgt_cmd_t c;
        c.word_addr = d.word_addr;
        c.wdata     = d.wdata;
        c.write     = d.write;
        c.wben      = d.wben;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // Grants
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            loader_want[t] = loader_valid && (loader_dec.target == t);
            imem_want[t]   = imem_valid && (imem_dec.target == t);
            dmem_want[t]   = dmem_valid && (dmem_dec.target == t);

            if (mode == router_pkg::MODE_BOOT) begin
                loader_grant[t] = loader_want[t];
                imem_grant[t]   = 1'b0;
                dmem_grant[t]   = 1'b0;
                conflict[t]     = 1'b0;
            end else begin
                loader_grant[t] = 1'b0;
                imem_grant[t]   = imem_want[t] && (!dmem_want[t] || favor_imem[t]);
                dmem_grant[t]   = dmem_want[t] && (!imem_want[t] || !favor_imem[t]);
                conflict[t]     = imem_want[t] && dmem_want[t];
            end
        end
    end

    assign loader_ready = |loader_grant;
    assign imem_ready   = |imem_grant;
    assign dmem_ready   = |dmem_grant;

    // Pick the winning request per target
    always_comb begin
        for (int t = 0; t < NUM_TGT; t++) begin
            if (imem_grant[t]) begin
                cmd_d[t]     = to_cmd(imem_dec);
                tag_d[t].src = router_pkg::SRC_IMEM;
            end else if (dmem_grant[t]) begin
                cmd_d[t]     = to_cmd(dmem_dec);
                tag_d[t].src = router_pkg::SRC_DMEM;
            end else begin
                cmd_d[t]       = to_cmd(loader_dec);
                // Boot traffic is write only
                cmd_d[t].write = 1'b1;
                tag_d[t].src   = router_pkg::SRC_LOADER;
            end
            tag_d[t].read = (imem_grant[t] || dmem_grant[t]) && !cmd_d[t].write;
        end
    end

    ////////////////////////////////////////////////////////////
    // State and command registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mode        <= router_pkg::MODE_BOOT;
            favor_imem  <= FAVOR_INIT;
            cmd_valid_q <= '0;
            for (int t = 0; t < NUM_TGT; t++) begin
                tag_q[t] <= '0;
            end
        end else begin
            if (mode == router_pkg::MODE_BOOT && boot_done) begin
                mode <= router_pkg::MODE_RUN;
            end
            favor_imem  <= favor_imem ^ conflict;
            cmd_valid_q <= loader_grant | imem_grant | dmem_grant;
            for (int t = 0; t < NUM_TGT; t++) begin
                tag_q[t] <= tag_d[t];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TGT; t++) begin
            if (loader_grant[t] || imem_grant[t] || dmem_grant[t]) begin
                cmd_q[t] <= cmd_d[t];
            end
        end
    end

    assign inst_cmd_valid = cmd_valid_q[router_pkg::TGT_INST];
    assign data_cmd_valid = cmd_valid_q[router_pkg::TGT_DATA];
    assign reg_cmd_valid  = cmd_valid_q[router_pkg::TGT_REG];
    assign inst_cmd       = cmd_q[router_pkg::TGT_INST];
    assign data_cmd       = cmd_q[router_pkg::TGT_DATA];
    assign reg_cmd        = cmd_q[router_pkg::TGT_REG];
    assign inst_tag       = tag_q[router_pkg::TGT_INST];
    assign data_tag       = tag_q[router_pkg::TGT_DATA];
    assign reg_tag        = tag_q[router_pkg::TGT_REG];

endmodule
